//--- src/pmp_pkg.sv
// ----------------------------------------------------------
// PMP package
// Shared encodings for the physical memory protection
// checker: privilege levels, access types, address modes,
// CSR select codes and the packed CSR layouts
// ----------------------------------------------------------
package pmp_pkg;

  // Entries covered by one pmpcfg word
  localparam int unsigned PMP_MAX_REGIONS = 4;

  // Privilege level, same coding as mstatus.MPP
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_S = 2'd1,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

  // Kind of access being checked
  typedef enum logic [1:0] {
    PMP_ACC_READ  = 2'd0,
    PMP_ACC_WRITE = 2'd1,
    PMP_ACC_EXEC  = 2'd2
  } pmp_acc_e;

  // Address matching mode, the A field of a config byte
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'd0,
    PMP_MODE_TOR   = 2'd1,
    PMP_MODE_NA4   = 2'd2,
    PMP_MODE_NAPOT = 2'd3
  } pmp_mode_e;

  // CSR select for the write port
  typedef enum logic [2:0] {
    CSR_PMPCFG0  = 3'd0,
    CSR_PMPADDR0 = 3'd1,
    CSR_PMPADDR1 = 3'd2,
    CSR_PMPADDR2 = 3'd3,
    CSR_PMPADDR3 = 3'd4,
    CSR_MSECCFG  = 3'd5
  } csr_sel_e;

  // One pmpcfg byte, msb first
  typedef struct packed {
    logic      lock;
    logic [1:0] reserved;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // Implemented mseccfg bits, rlb in bit 2 down to mml in bit 0
  typedef struct packed {
    logic rlb;
    logic mmwp;
    logic mml;
  } pmp_mseccfg_t;

  // CSR write data, seen raw or as four config bytes
  typedef union packed {
    logic [31:0]                    raw;
    pmp_cfg_t [PMP_MAX_REGIONS-1:0] cfg;
  } pmp_csr_word_u;

endpackage

//--- src/pmp_cfg_if.sv
// ----------------------------------------------------------
// PMP configuration bundle
// Stored region configuration, as seen by the address
// matcher, the permission checker and the fault resolver
// ----------------------------------------------------------
interface pmp_cfg_if
  import pmp_pkg::*;
#(
  parameter int unsigned NUM_REGIONS = PMP_MAX_REGIONS
);

  // Per-entry config bytes
  pmp_cfg_t     cfg  [NUM_REGIONS];
  // Byte addresses, pmpaddr with two zero bits below
  logic [33:0]  addr [NUM_REGIONS];
  // Machine security configuration
  pmp_mseccfg_t mseccfg;

  modport csr     (output cfg, output addr, output mseccfg);
  modport match   (input cfg, input addr);
  modport perm    (input cfg);
  modport resolve (input cfg, input mseccfg);

endinterface

//--- src/pmp_csr_regs.sv
// ----------------------------------------------------------
// PMP CSR storage
// Holds pmpcfg0, pmpaddr0..N-1 and mseccfg. Applies the
// entry lock, the TOR lock on the previous address and the
// sticky mseccfg bits on every write
// ----------------------------------------------------------
module pmp_csr_regs
  import pmp_pkg::*;
#(
  parameter int unsigned NUM_REGIONS = PMP_MAX_REGIONS
) (
  input  logic          clk,
  input  logic          rst_i,
  input  logic          csr_we_i,
  input  csr_sel_e      csr_sel_i,
  input  pmp_csr_word_u csr_wdata_i,
  pmp_cfg_if.csr        cfg_o
);

  // Reserved bits 6:5 of a config byte always read zero
  localparam logic [7:0] CfgWrMask = 8'h9F;

  pmp_cfg_t               cfg_q   [NUM_REGIONS];
  logic [31:0]            addr_q  [NUM_REGIONS];
  pmp_mseccfg_t           mseccfg_q;
  pmp_mseccfg_t           mseccfg_wr;
  logic [NUM_REGIONS-1:0] cfg_locked;
  logic [NUM_REGIONS-1:0] addr_locked;
  logic [NUM_REGIONS-1:0] addr_sel;
  logic                   any_locked;

  // ----------------------------------------------------------
  // Write protection
  // ----------------------------------------------------------
  always_comb begin
    any_locked = 1'b0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      // Lock holds unless rule locking bypass is on
      cfg_locked[i] = cfg_q[i].lock && !mseccfg_q.rlb;
      any_locked    = any_locked || cfg_q[i].lock;
      addr_sel[i]   = int'(csr_sel_i) == int'(CSR_PMPADDR0) + i;
    end
    for (int i = 0; i < NUM_REGIONS; i++) begin
      addr_locked[i] = cfg_locked[i];
      // A locked TOR entry also freezes the address below it
      if (i + 1 < NUM_REGIONS) begin
        addr_locked[i] = addr_locked[i] ||
                         (cfg_locked[i+1] && cfg_q[i+1].mode == PMP_MODE_TOR);
      end
    end
  end

  // ----------------------------------------------------------
  // Entry registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        cfg_q[i]  <= '0;
        addr_q[i] <= '0;
      end
    end else if (csr_we_i) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        // pmpcfg0 is decoded byte by byte
        if (csr_sel_i == CSR_PMPCFG0 && !cfg_locked[i]) begin
          cfg_q[i] <= pmp_cfg_t'(csr_wdata_i.cfg[i] & CfgWrMask);
        end
        if (addr_sel[i] && !addr_locked[i]) begin
          addr_q[i] <= csr_wdata_i.raw;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // mseccfg
  // ----------------------------------------------------------
  assign mseccfg_wr = pmp_mseccfg_t'(csr_wdata_i.raw[2:0]);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      mseccfg_q <= '0;
    end else if (csr_we_i && csr_sel_i == CSR_MSECCFG) begin
      // mml and mmwp only ever get set
      mseccfg_q.mml  <= mseccfg_q.mml  || mseccfg_wr.mml;
      mseccfg_q.mmwp <= mseccfg_q.mmwp || mseccfg_wr.mmwp;
      // rlb cannot be turned on once something is locked
      if (mseccfg_q.rlb || !any_locked) begin
        mseccfg_q.rlb <= mseccfg_wr.rlb;
      end
    end
  end

  // Drive the bundle
  for (genvar i = 0; i < NUM_REGIONS; i++) begin : g_out
    assign cfg_o.cfg[i]  = cfg_q[i];
    assign cfg_o.addr[i] = {addr_q[i], 2'b00};
  end
  assign cfg_o.mseccfg = mseccfg_q;

endmodule

//--- src/pmp_region_match.sv
// ----------------------------------------------------------
// PMP address matcher
// Compares the request address with every region under its
// OFF, TOR, NA4 or NAPOT mode and returns a hit per region
// ----------------------------------------------------------
module pmp_region_match
  import pmp_pkg::*;
#(
  parameter int unsigned NUM_REGIONS = PMP_MAX_REGIONS,
  parameter int unsigned GRANULARITY = 0
) (
  pmp_cfg_if.match               cfg_i,
  input  logic [33:0]            req_addr_i,
  output logic [NUM_REGIONS-1:0] match_vec_o
);

  // Lowest address bit that takes part in any comparison
  localparam int unsigned LoBit  = GRANULARITY + 2;
  // Lowest stored bit whose trailing ones count for NAPOT size
  localparam int unsigned OnesLo = (GRANULARITY == 0) ? 2 : GRANULARITY + 1;

  logic [33:LoBit] req_gran;

  // Request address at granule resolution
  assign req_gran = req_addr_i[33:LoBit];

  for (genvar r = 0; r < NUM_REGIONS; r++) begin : g_region
    logic [33:LoBit] start_gran;
    logic [33:LoBit] end_gran;
    logic [33:LoBit] cmp_mask;
    logic            is_napot;
    logic            hit_eq;
    logic            hit_tor;
    logic            hit;

    assign is_napot = cfg_i.cfg[r].mode == PMP_MODE_NAPOT;
    assign end_gran = cfg_i.addr[r][33:LoBit];

    // TOR base, entry 0 starts at address zero
    if (r == 0) begin : g_base_zero
      assign start_gran = '0;
    end else begin : g_base_prev
      assign start_gran = cfg_i.addr[r-1][33:LoBit];
    end

    // Compare mask, NAPOT drops the bits covered by the size
    for (genvar b = LoBit; b < 34; b++) begin : g_mask
      if (b == 2) begin : g_min_size
        // Smallest NAPOT region is 8 bytes
        assign cmp_mask[b] = !is_napot;
      end else begin : g_size
        // Masked while every stored bit below is a one
        assign cmp_mask[b] = !is_napot || !(&cfg_i.addr[r][b-1:OnesLo]);
      end
    end

    assign hit_eq  = ((req_gran ^ end_gran) & cmp_mask) == '0;
    // TOR range is [previous, own)
    assign hit_tor = (req_gran >= start_gran) && (req_gran < end_gran);

    always_comb begin
      case (cfg_i.cfg[r].mode)
        PMP_MODE_TOR:   hit = hit_tor;
        PMP_MODE_NA4:   hit = hit_eq;
        PMP_MODE_NAPOT: hit = hit_eq;
        default:        hit = 1'b0;
      endcase
    end

    assign match_vec_o[r] = hit;
  end

endmodule

//--- src/pmp_perm_check.sv
// ----------------------------------------------------------
// PMP permission checker
// Evaluates every region's R/W/X/L bits against the access
// under the basic rules and under the Smepmp MML table
// ----------------------------------------------------------
module pmp_perm_check
  import pmp_pkg::*;
#(
  parameter int unsigned NUM_REGIONS = PMP_MAX_REGIONS
) (
  pmp_cfg_if.perm                cfg_i,
  input  pmp_acc_e               req_type_i,
  input  priv_lvl_e              priv_i,
  output logic [NUM_REGIONS-1:0] basic_ok_o,
  output logic [NUM_REGIONS-1:0] mml_ok_o
);

  logic is_read;
  logic is_write;
  logic is_exec;
  logic is_m;

  // Decoded access and level, shared by all regions
  assign is_read  = req_type_i == PMP_ACC_READ;
  assign is_write = req_type_i == PMP_ACC_WRITE;
  assign is_exec  = req_type_i == PMP_ACC_EXEC;
  assign is_m     = priv_i == PRIV_LVL_M;

  for (genvar r = 0; r < NUM_REGIONS; r++) begin : g_region
    pmp_cfg_t cfg;
    logic     basic_ok;
    logic     mml_ok;

    assign cfg = cfg_i.cfg[r];

    // Permission bit that goes with the access type
    assign basic_ok = (is_read  && cfg.read)  ||
                      (is_write && cfg.write) ||
                      (is_exec  && cfg.exec);

    always_comb begin
      mml_ok = 1'b0;
      if (!cfg.read && cfg.write) begin
        // Shared regions, chosen by L and X
        case ({cfg.lock, cfg.exec})
          // RW in M, read only below
          2'b00: mml_ok = is_read || (is_write && is_m);
          // RW everywhere
          2'b01: mml_ok = is_read || is_write;
          // Execute only everywhere
          2'b10: mml_ok = is_exec;
          // RX in M, execute only below
          default: mml_ok = is_exec || (is_read && is_m);
        endcase
      end else if (cfg.read && cfg.write && cfg.exec && cfg.lock) begin
        // Read only shared data
        mml_ok = is_read;
      end else if (is_m) begin
        // Locked entries belong to M
        mml_ok = cfg.lock && basic_ok;
      end else begin
        mml_ok = !cfg.lock && basic_ok;
      end
    end

    assign basic_ok_o[r] = basic_ok;
    assign mml_ok_o[r]   = mml_ok;
  end

endmodule

//--- src/pmp_fault_resolve.sv
// ----------------------------------------------------------
// PMP fault resolver
// Picks the lowest matching region, applies the basic or
// MML outcome or the default policy, registers the fault
// ----------------------------------------------------------
module pmp_fault_resolve
  import pmp_pkg::*;
#(
  parameter int unsigned NUM_REGIONS = PMP_MAX_REGIONS
) (
  input  logic                   clk,
  input  logic                   rst_i,
  pmp_cfg_if.resolve             cfg_i,
  input  logic                   req_valid_i,
  input  priv_lvl_e              priv_i,
  input  logic [NUM_REGIONS-1:0] match_vec_i,
  input  logic [NUM_REGIONS-1:0] basic_ok_i,
  input  logic [NUM_REGIONS-1:0] mml_ok_i,
  output logic                   err_o,
  output logic                   err_valid_o
);

  logic fault;

  always_comb begin
    // No match: deny with mmwp or below M
    fault = cfg_i.mseccfg.mmwp || (priv_i != PRIV_LVL_M);
    // Walk down so the lowest index is applied last
    for (int r = NUM_REGIONS - 1; r >= 0; r--) begin
      if (match_vec_i[r]) begin
        if (cfg_i.mseccfg.mml) begin
          fault = !mml_ok_i[r];
        end else if (priv_i == PRIV_LVL_M) begin
          // M is only held back by locked entries
          fault = cfg_i.cfg[r].lock && !basic_ok_i[r];
        end else begin
          fault = !basic_ok_i[r];
        end
      end
    end
  end

  // Result one cycle after the request
  always_ff @(posedge clk) begin
    if (rst_i) begin
      err_valid_o <= 1'b0;
      err_o       <= 1'b0;
    end else begin
      err_valid_o <= req_valid_i;
      err_o       <= req_valid_i && fault;
    end
  end

endmodule

//--- src/pmp_top.sv
// ----------------------------------------------------------
// PMP checker top
// CSR storage plus the matcher, permission checker and
// fault resolver, answering one access per cycle
// ----------------------------------------------------------
module pmp_top
  import pmp_pkg::*;
#(
  parameter int unsigned NUM_REGIONS = PMP_MAX_REGIONS,
  parameter int unsigned GRANULARITY = 0
) (
  input  logic        clk,
  input  logic        rst_i,
  // CSR write port
  input  logic        csr_we_i,
  input  csr_sel_e    csr_sel_i,
  input  logic [31:0] csr_wdata_i,
  // Access request
  input  logic        req_valid_i,
  input  logic [33:0] req_addr_i,
  input  pmp_acc_e    req_type_i,
  input  priv_lvl_e   priv_i,
  // Registered result
  output logic        err_o,
  output logic        err_valid_o
);

  logic [NUM_REGIONS-1:0] match_vec;
  logic [NUM_REGIONS-1:0] basic_ok;
  logic [NUM_REGIONS-1:0] mml_ok;

  // Stored configuration shared by all parts
  pmp_cfg_if #(.NUM_REGIONS(NUM_REGIONS)) u_cfg_if ();

  pmp_csr_regs #(.NUM_REGIONS(NUM_REGIONS)) u_csr_regs (
    .clk         (clk),
    .rst_i       (rst_i),
    .csr_we_i    (csr_we_i),
    .csr_sel_i   (csr_sel_i),
    .csr_wdata_i (csr_wdata_i),
    .cfg_o       (u_cfg_if.csr)
  );

  // Matcher and permission checker work side by side
  pmp_region_match #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) u_region_match (
    .cfg_i       (u_cfg_if.match),
    .req_addr_i  (req_addr_i),
    .match_vec_o (match_vec)
  );

  pmp_perm_check #(.NUM_REGIONS(NUM_REGIONS)) u_perm_check (
    .cfg_i      (u_cfg_if.perm),
    .req_type_i (req_type_i),
    .priv_i     (priv_i),
    .basic_ok_o (basic_ok),
    .mml_ok_o   (mml_ok)
  );

  pmp_fault_resolve #(.NUM_REGIONS(NUM_REGIONS)) u_fault_resolve (
    .clk         (clk),
    .rst_i       (rst_i),
    .cfg_i       (u_cfg_if.resolve),
    .req_valid_i (req_valid_i),
    .priv_i      (priv_i),
    .match_vec_i (match_vec),
    .basic_ok_i  (basic_ok),
    .mml_ok_i    (mml_ok),
    .err_o       (err_o),
    .err_valid_o (err_valid_o)
  );

endmodule

//--- tests/pmp_properties.sv
// ----------------------------------------------------------
// PMP output timing properties
// Result strobe timing and known fault value, bound to
// the checker top level
// ----------------------------------------------------------
module pmp_properties (
  input logic clk_i,
  input logic rst_i,
  input logic req_valid_i,
  input logic err_i,
  input logic err_valid_i
);

  // Failed assertions, read back at the end of the run
  int unsigned fail_count = 0;

  // One result strobe per request, exactly one cycle later
  a_valid_follows_req: assert property (@(posedge clk_i) disable iff (rst_i)
    err_valid_i == $past(req_valid_i))
    else begin
      fail_count++;
      $error("err_valid_o does not follow req_valid_i by one cycle");
    end

  // Nothing left over from reset
  a_idle_after_reset: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !err_valid_i)
    else begin
      fail_count++;
      $error("err_valid_o high in the first cycle after reset");
    end

  a_err_known: assert property (@(posedge clk_i) disable iff (rst_i)
    err_valid_i |-> !$isunknown(err_i))
    else begin
      fail_count++;
      $error("err_o unknown while err_valid_o is high");
    end

endmodule

bind pmp_top pmp_properties u_properties (
  .clk_i       (clk),
  .rst_i       (rst_i),
  .req_valid_i (req_valid_i),
  .err_i       (err_o),
  .err_valid_i (err_valid_o)
);

//--- tests/pmp_checker.sv
// ----------------------------------------------------------
// PMP result checker
// Pairs each err_valid_o strobe with the oldest expected
// fault, counts errors and prints the closing counts
// ----------------------------------------------------------
module pmp_checker (
  input logic clk_i,
  input logic rst_i,
  input logic err_i,
  input logic err_valid_i
);

  // Expected faults, oldest first
  logic        exp_q[$];
  int unsigned error_count   = 0;
  int unsigned checked_count = 0;

  function automatic void push_expected(input logic exp_err);
    exp_q.push_back(exp_err);
  endfunction

  function automatic int unsigned pending();
    return exp_q.size();
  endfunction

  // Registered outputs are settled by the falling edge
  always @(negedge clk_i) begin
    logic exp_err;
    if (!rst_i && err_valid_i) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("Result strobe at %0t with no request outstanding", $time);
      end else begin
        exp_err = exp_q.pop_front();
        checked_count++;
        if (err_i !== exp_err) begin
          error_count++;
          $display("Mismatch err_o at %0t: got 0x%0h, expected 0x%0h",
                   $time, err_i, exp_err);
        end
      end
    end
  end

  task automatic print_summary(input int unsigned assert_fails);
    // Requests that never got an answer
    if (exp_q.size() != 0) begin
      error_count += exp_q.size();
      $display("No result seen for %0d requests", exp_q.size());
    end
    $display("Checked %0d results, %0d errors, %0d assertion failures",
             checked_count, error_count, assert_fails);
  endtask

endmodule

//--- tests/pmp_tb.sv
// ----------------------------------------------------------
// PMP checker testbench
// Table of CSR writes and access requests, one row per
// cycle, with expected faults handed to the result checker
// ----------------------------------------------------------
module pmp_tb
  import pmp_pkg::*;
();

  // One table row holds either a CSR write or a checked access
  typedef struct {
    logic        is_csr;
    csr_sel_e    sel;
    logic [31:0] data;
    logic [33:0] addr;
    pmp_acc_e    acc;
    priv_lvl_e   priv;
    logic        exp_err;
  } row_t;

  logic        clk;
  logic        rst;
  logic        csr_we;
  csr_sel_e    csr_sel;
  logic [31:0] csr_wdata;
  logic        req_valid;
  logic [33:0] req_addr;
  pmp_acc_e    req_type;
  priv_lvl_e   priv;
  logic        err;
  logic        err_valid;

  row_t        rows[$];
  int unsigned cycle_count = 0;
  int unsigned timeout_limit;

  pmp_top #(.NUM_REGIONS(4), .GRANULARITY(0)) i_pmp_top (
    .clk         (clk),
    .rst_i       (rst),
    .csr_we_i    (csr_we),
    .csr_sel_i   (csr_sel),
    .csr_wdata_i (csr_wdata),
    .req_valid_i (req_valid),
    .req_addr_i  (req_addr),
    .req_type_i  (req_type),
    .priv_i      (priv),
    .err_o       (err),
    .err_valid_o (err_valid)
  );

  pmp_checker i_checker (
    .clk_i       (clk),
    .rst_i       (rst),
    .err_i       (err),
    .err_valid_i (err_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run limit of the table length plus reset and drain
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: run still busy after %0d cycles", cycle_count);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic csr_write_row(input csr_sel_e sel, input logic [31:0] data);
    row_t r;
    r = '{1'b1, sel, data, 34'h0, PMP_ACC_READ, PRIV_LVL_M, 1'b0};
    rows.push_back(r);
  endtask

  task automatic access_row(input logic [33:0] addr, input pmp_acc_e acc,
                            input priv_lvl_e lvl, input logic exp_err);
    row_t r;
    r = '{1'b0, CSR_PMPCFG0, 32'h0, addr, acc, lvl, exp_err};
    rows.push_back(r);
  endtask

  initial begin
    int unsigned off;
    void'($urandom(36));
    rst       = 1'b1;
    csr_we    = 1'b0;
    csr_sel   = CSR_PMPCFG0;
    csr_wdata = '0;
    req_valid = 1'b0;
    req_addr  = '0;
    req_type  = PMP_ACC_READ;
    priv      = PRIV_LVL_M;

    // Reset defaults with nothing configured
    access_row(34'h0000, PMP_ACC_READ, PRIV_LVL_M, 1'b0);
    access_row(34'h0000, PMP_ACC_READ, PRIV_LVL_U, 1'b1);
    // TOR [0,0x1000) R, NA4 0x1000 RW, NAPOT 64B at 0x2000 RWX
    csr_write_row(CSR_PMPADDR0, 32'h400);
    csr_write_row(CSR_PMPADDR1, 32'h400);
    csr_write_row(CSR_PMPADDR2, 32'h807);
    csr_write_row(CSR_PMPCFG0, 32'h001F_1309);
    access_row(34'h0FFF, PMP_ACC_WRITE, PRIV_LVL_U, 1'b1);
    access_row(34'h1000, PMP_ACC_WRITE, PRIV_LVL_U, 1'b0);
    access_row(34'h1004, PMP_ACC_READ, PRIV_LVL_U, 1'b1);
    access_row(34'h203F, PMP_ACC_EXEC, PRIV_LVL_U, 1'b0);
    access_row(34'h2040, PMP_ACC_EXEC, PRIV_LVL_U, 1'b1);
    access_row(34'h2040, PMP_ACC_READ, PRIV_LVL_M, 1'b0);
    // Region 3 is a read only NAPOT 128B at 0x2000 under region 2
    csr_write_row(CSR_PMPADDR3, 32'h80F);
    csr_write_row(CSR_PMPCFG0, 32'h191F_1309);
    access_row(34'h2010, PMP_ACC_WRITE, PRIV_LVL_U, 1'b0);
    access_row(34'h2050, PMP_ACC_WRITE, PRIV_LVL_U, 1'b1);
    access_row(34'h2050, PMP_ACC_READ, PRIV_LVL_U, 1'b0);
    access_row(34'h0100, PMP_ACC_WRITE, PRIV_LVL_M, 1'b0);
    // Lock NA4 RW and a TOR RWX region up to 0x3000
    csr_write_row(CSR_PMPADDR3, 32'hC00);
    csr_write_row(CSR_PMPCFG0, 32'h8F1F_9309);
    access_row(34'h1000, PMP_ACC_EXEC, PRIV_LVL_M, 1'b1);
    // Rewrites of locked entries are dropped
    csr_write_row(CSR_PMPCFG0, 32'h001F_1F09);
    csr_write_row(CSR_PMPADDR1, 32'h500);
    csr_write_row(CSR_PMPADDR2, 32'h900);
    csr_write_row(CSR_PMPADDR3, 32'h1000);
    access_row(34'h2800, PMP_ACC_READ, PRIV_LVL_U, 1'b0);
    access_row(34'h1000, PMP_ACC_EXEC, PRIV_LVL_U, 1'b1);
    access_row(34'h1400, PMP_ACC_READ, PRIV_LVL_U, 1'b1);
    access_row(34'h3000, PMP_ACC_EXEC, PRIV_LVL_U, 1'b1);
    access_row(34'h2030, PMP_ACC_WRITE, PRIV_LVL_U, 1'b0);
    // Anywhere inside the NA4 word
    for (int k = 0; k < 2; k++) begin
      off = $urandom % 4;
      access_row(34'h1000 + off, PMP_ACC_WRITE, PRIV_LVL_U, 1'b0);
      access_row(34'h1000 + off, PMP_ACC_EXEC, PRIV_LVL_U, 1'b1);
    end
    // MML on
    csr_write_row(CSR_MSECCFG, 32'h1);
    access_row(34'h0100, PMP_ACC_READ, PRIV_LVL_M, 1'b1);
    access_row(34'h1000, PMP_ACC_READ, PRIV_LVL_U, 1'b1);
    // Locked RWX region 3 turns into read only shared data
    access_row(34'h2800, PMP_ACC_WRITE, PRIV_LVL_U, 1'b1);
    access_row(34'h2800, PMP_ACC_READ, PRIV_LVL_U, 1'b0);
    // Shared L0 X0
    csr_write_row(CSR_PMPCFG0, 32'h001A_0009);
    access_row(34'h2010, PMP_ACC_WRITE, PRIV_LVL_M, 1'b0);
    access_row(34'h2010, PMP_ACC_WRITE, PRIV_LVL_U, 1'b1);
    // Shared L0 X1
    csr_write_row(CSR_PMPCFG0, 32'h001E_0009);
    access_row(34'h2010, PMP_ACC_WRITE, PRIV_LVL_U, 1'b0);
    access_row(34'h2010, PMP_ACC_WRITE, PRIV_LVL_M, 1'b0);
    // Shared L1 X0 on region 0 and L1 X1 on region 2
    csr_write_row(CSR_PMPCFG0, 32'h009E_008A);
    access_row(34'h0100, PMP_ACC_EXEC, PRIV_LVL_U, 1'b0);
    access_row(34'h0100, PMP_ACC_READ, PRIV_LVL_M, 1'b1);
    access_row(34'h2010, PMP_ACC_READ, PRIV_LVL_M, 1'b0);
    access_row(34'h2010, PMP_ACC_READ, PRIV_LVL_U, 1'b1);
    // MMWP denies unmatched M and both bits stay set
    csr_write_row(CSR_MSECCFG, 32'h2);
    access_row(34'h5000, PMP_ACC_READ, PRIV_LVL_M, 1'b1);
    csr_write_row(CSR_MSECCFG, 32'h0);
    access_row(34'h5000, PMP_ACC_READ, PRIV_LVL_M, 1'b1);
    access_row(34'h2800, PMP_ACC_WRITE, PRIV_LVL_U, 1'b1);

    timeout_limit = rows.size() + 20;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    foreach (rows[i]) begin
      @(posedge clk);
      csr_we    <= rows[i].is_csr;
      csr_sel   <= rows[i].sel;
      csr_wdata <= rows[i].data;
      req_valid <= !rows[i].is_csr;
      req_addr  <= rows[i].addr;
      req_type  <= rows[i].acc;
      priv      <= rows[i].priv;
      if (!rows[i].is_csr) begin
        i_checker.push_expected(rows[i].exp_err);
      end
    end
    @(posedge clk);
    csr_we    <= 1'b0;
    req_valid <= 1'b0;
    // Wait for the last result
    while (i_checker.pending() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    i_checker.print_summary(i_pmp_top.u_properties.fail_count);
    if (i_checker.error_count == 0 && i_pmp_top.u_properties.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- pmp.f
src/pmp_pkg.sv
src/pmp_cfg_if.sv
src/pmp_csr_regs.sv
src/pmp_region_match.sv
src/pmp_perm_check.sv
src/pmp_fault_resolve.sv
src/pmp_top.sv
tests/pmp_properties.sv
tests/pmp_checker.sv
tests/pmp_tb.sv

//--- Bender.yml
package:
  name: pmp

sources:
  - src/pmp_pkg.sv
  - src/pmp_cfg_if.sv
  - src/pmp_csr_regs.sv
  - src/pmp_region_match.sv
  - src/pmp_perm_check.sv
  - src/pmp_fault_resolve.sv
  - src/pmp_top.sv
  - target: test
    files:
      - tests/pmp_properties.sv
      - tests/pmp_checker.sv
      - tests/pmp_tb.sv
